/* source/box_pkg.sv */
`default_nettype none

// shared widths and sizes for the box filter engine
// every rtl file and the testbench pull these in with a wildcard import
package box_pkg;

	// one sensor pixel, max value 4095
	localparam int PIXEL_W = 12;

	// window edge in pixels
	// the same value is the number of window rows and the number of taps per row
	localparam int WIN_SIZE = 3;

	// one row sum holds three full scale pixels, 3 * 4095 = 12285
	localparam int ROW_SUM_W = 14;

	// box sum of nine full scale pixels is 36855, below 65535
	localparam int BOX_SUM_W = 16;

	// pixels per image line, each line fifo delays by exactly this many strobes
	localparam int FRAME_WIDTH = 10;

	// column counter and line fifo address width, must cover FRAME_WIDTH - 1
	localparam int COL_W = 4;

	// row counter width, it only counts up to WIN_SIZE - 1 and then saturates
	localparam int ROW_W = 2;

endpackage

`default_nettype wire

/* source/pixel_capture.sv */
`timescale 1ns/10ps
`default_nettype none

// input stage, registers the strobe and pixel and works out where the pixel sits
module pixel_capture
	import box_pkg::*;
(
	input  logic               clk_os,
	input  logic               reset_os,
	input  logic               i_pixel_valid,  // one strobe per pixel, no back-pressure
	input  logic [PIXEL_W-1:0] i_pixel,
	input  logic               i_frame_start,  // only looked at together with a strobe
	output logic               o_valid,
	output logic [PIXEL_W-1:0] o_pixel,
	output logic               o_window_full
);

	logic [COL_W-1:0] col_cnt;  // column of the next pixel to arrive
	logic [ROW_W-1:0] row_cnt;  // row of the next pixel, stuck at WIN_SIZE - 1
	logic [COL_W-1:0] cur_col;  // position of the pixel on the input right now
	logic [ROW_W-1:0] cur_row;
	logic             last_col;

	// a frame start strobe puts this pixel at row 0, column 0 whatever the counters say
	always_comb
	begin
		if (i_frame_start)
		begin
			cur_col = '0;
			cur_row = '0;
		end
		else
		begin
			cur_col = col_cnt;
			cur_row = row_cnt;
		end
	end

	assign last_col = (cur_col == COL_W'(FRAME_WIDTH - 1));

	// position counters move on strobes only, idle cycles leave them alone
	always_ff @(posedge clk_os or posedge reset_os)
	begin
		if (reset_os)
		begin
			col_cnt <= '0;
			row_cnt <= '0;
		end
		else if (i_pixel_valid)
		begin
			if (last_col)
			begin
				col_cnt <= '0;  // wrap to the start of the next line
				if (cur_row != ROW_W'(WIN_SIZE - 1))
					row_cnt <= cur_row + 1'b1;
				else
					row_cnt <= cur_row;  // beyond row 2 the exact row no longer matters
			end
			else
			begin
				col_cnt <= cur_col + 1'b1;
				row_cnt <= cur_row;
			end
		end
	end

	// strobe and flag, the flag holds between strobes
	always_ff @(posedge clk_os or posedge reset_os)
	begin
		if (reset_os)
		begin
			o_valid       <= 1'b0;
			o_window_full <= 1'b0;
		end
		else
		begin
			o_valid <= i_pixel_valid;  // exactly one cycle per sampled strobe
			if (i_pixel_valid)
				o_window_full <= (cur_col >= COL_W'(WIN_SIZE - 1)) &&
					(cur_row == ROW_W'(WIN_SIZE - 1));
		end
	end

	always_ff @(posedge clk_os)
	begin
		if (i_pixel_valid)
			o_pixel <= i_pixel;  // pixel payload
	end

	// the column counter has to stay inside the line
	a_col_range: assert property (@(posedge clk_os) disable iff (reset_os)
		col_cnt < COL_W'(FRAME_WIDTH));

	// the sensor side is expected to stay quiet while the engine sits in reset
	a_no_strobe_in_reset: assert property (@(posedge clk_os) reset_os |-> !i_pixel_valid);

endmodule

`default_nettype wire

/* source/line_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

// one line delay, hands back the sample written FRAME_WIDTH strobes ago
// a single address serves both sides, the old entry is read and then overwritten
module line_fifo
	import box_pkg::*;
(
	input  logic               clk_os,
	input  logic               reset_os,
	input  logic               i_valid,       // advance by one sample
	input  logic [PIXEL_W-1:0] i_pixel,
	output logic [PIXEL_W-1:0] o_line_pixel   // same column, one line earlier
);

	logic [PIXEL_W-1:0] line_mem [FRAME_WIDTH];
	logic [COL_W-1:0]   addr;    // current slot, read now and written on the strobe
	logic               filled;  // set once every slot has been written after reset
	logic               addr_last;

	assign addr_last = (addr == COL_W'(FRAME_WIDTH - 1));

	// read side is combinational so the consumer sees the old sample in the
	// same cycle as the strobe that replaces it
	// before the first full pass the memory holds garbage, show zero instead
	assign o_line_pixel = filled ? line_mem[addr] : '0;

	// address walks one slot per strobe, delay counts strobes and not cycles
	always_ff @(posedge clk_os or posedge reset_os)
	begin
		if (reset_os)
		begin
			addr   <= '0;
			filled <= 1'b0;
		end
		else if (i_valid)
		begin
			if (addr_last)
			begin
				addr   <= '0;
				filled <= 1'b1;  // sticky until the next reset
			end
			else
			begin
				addr <= addr + 1'b1;
			end
		end
	end

	// storage itself
	always_ff @(posedge clk_os)
	begin
		if (i_valid)
			line_mem[addr] <= i_pixel;
	end

	// slot index must never leave the memory
	a_addr_range: assert property (@(posedge clk_os) disable iff (reset_os)
		addr < COL_W'(FRAME_WIDTH));

endmodule

`default_nettype wire

/* source/box_row.sv */
`timescale 1ns/10ps
`default_nettype none

// horizontal running sum over the last WIN_SIZE samples of one window row
module box_row
	import box_pkg::*;
(
	input  logic                 clk_os,
	input  logic                 reset_os,
	input  logic                 i_valid,    // one new sample per strobe
	input  logic [PIXEL_W-1:0]   i_pixel,
	output logic [ROW_SUM_W-1:0] o_row_sum   // sum of the current taps
);

	logic [PIXEL_W-1:0]   taps [WIN_SIZE];  // taps[0] is the newest sample
	logic [ROW_SUM_W-1:0] run_sum;
	logic [ROW_SUM_W-1:0] tap_total;        // brute force total, only for checking

	assign o_row_sum = run_sum;

	// the tap line shifts one place per strobe
	always_ff @(posedge clk_os or posedge reset_os)
	begin
		if (reset_os)
		begin
			for (int i = 0; i < WIN_SIZE; i++)
				taps[i] <= '0;
		end
		else if (i_valid)
		begin
			taps[0] <= i_pixel;
			for (int i = 1; i < WIN_SIZE; i++)
				taps[i] <= taps[i-1];
		end
	end

	// add the sample coming in and drop the one falling off the far end
	// the oldest tap is always part of run_sum, so the subtraction never goes negative
	always_ff @(posedge clk_os or posedge reset_os)
	begin
		if (reset_os)
		begin
			run_sum <= '0;
		end
		else if (i_valid)
		begin
			run_sum <= run_sum + ROW_SUM_W'(i_pixel) - ROW_SUM_W'(taps[WIN_SIZE-1]);
		end
	end

	// plain adder over all taps, gives the assertion something independent to compare to
	always_comb
	begin
		tap_total = '0;
		for (int i = 0; i < WIN_SIZE; i++)
			tap_total = tap_total + ROW_SUM_W'(taps[i]);
	end

	// the incremental sum must never drift away from the real tap total
	a_no_drift: assert property (@(posedge clk_os) disable iff (reset_os)
		i_valid |=> (run_sum == tap_total));

endmodule

`default_nettype wire

/* source/box_output.sv */
`timescale 1ns/10ps
`default_nettype none

// output stage, adds the row sums into the box sum and lines the flags up with it
module box_output
	import box_pkg::*;
(
	input  logic                 clk_os,
	input  logic                 reset_os,
	input  logic                 i_valid,        // capture strobe, one stage ahead of the row sums
	input  logic                 i_window_full,
	input  logic [ROW_SUM_W-1:0] i_row_sums [WIN_SIZE],
	output logic                 o_sum_valid,
	output logic [BOX_SUM_W-1:0] o_box_sum,
	output logic                 o_window_full   // only ever high together with o_sum_valid
);

	logic                 valid_d;  // strobe delayed to the cycle the row sums are ready
	logic                 full_d;
	logic [BOX_SUM_W-1:0] box_total;

	// widen each row before adding so nine full scale pixels still fit
	always_comb
	begin
		box_total = '0;
		for (int i = 0; i < WIN_SIZE; i++)
			box_total = box_total + BOX_SUM_W'(i_row_sums[i]);
	end

	always_ff @(posedge clk_os or posedge reset_os)
	begin
		if (reset_os)
		begin
			valid_d       <= 1'b0;
			full_d        <= 1'b0;
			o_sum_valid   <= 1'b0;
			o_window_full <= 1'b0;
		end
		else
		begin
			valid_d       <= i_valid;
			full_d        <= i_valid & i_window_full;  // flag is stale between strobes
			o_sum_valid   <= valid_d;
			o_window_full <= valid_d & full_d;
		end
	end

	always_ff @(posedge clk_os)
	begin
		if (valid_d)
			o_box_sum <= box_total;  // holds the last sum while idle
	end

	// a full window sum never goes above nine full scale pixels
	// a larger value means one of the row summers has drifted or wrapped
	a_full_sum_range: assert property (@(posedge clk_os) disable iff (reset_os)
		o_window_full |-> (o_box_sum <= BOX_SUM_W'(WIN_SIZE * WIN_SIZE * ((1 << PIXEL_W) - 1))));

endmodule

`default_nettype wire

/* source/box_filter_top.sv */
`timescale 1ns/10ps
`default_nettype none

// 3x3 box filter engine, raster pixels in, box sums out two cycles later
module box_filter_top
	import box_pkg::*;
(
	input  logic                 clk_os,
	input  logic                 reset_os,
	input  logic                 i_pixel_valid,
	input  logic [PIXEL_W-1:0]   i_pixel,
	input  logic                 i_frame_start,
	output logic                 o_sum_valid,
	output logic [BOX_SUM_W-1:0] o_box_sum,
	output logic                 o_window_full
);

	logic                 cap_valid;
	logic [PIXEL_W-1:0]   cap_pixel;     // current line
	logic                 cap_full;
	logic [PIXEL_W-1:0]   line1_pixel;   // same column, one line up
	logic [PIXEL_W-1:0]   line2_pixel;   // same column, two lines up
	logic [ROW_SUM_W-1:0] row_sum_0;
	logic [ROW_SUM_W-1:0] row_sum_1;
	logic [ROW_SUM_W-1:0] row_sum_2;
	logic [ROW_SUM_W-1:0] row_sums [WIN_SIZE];

	// gather the three row sums for the output adder, newest line first
	assign row_sums[0] = row_sum_0;
	assign row_sums[1] = row_sum_1;
	assign row_sums[2] = row_sum_2;

	pixel_capture u_capture (.clk_os(clk_os), .reset_os(reset_os),
		.i_pixel_valid(i_pixel_valid), .i_pixel(i_pixel), .i_frame_start(i_frame_start),
		.o_valid(cap_valid), .o_pixel(cap_pixel), .o_window_full(cap_full));

	// two line delays in series give the two rows above the current one
	line_fifo line_fifo_0 (.clk_os(clk_os), .reset_os(reset_os),
		.i_valid(cap_valid), .i_pixel(cap_pixel), .o_line_pixel(line1_pixel));

	line_fifo line_fifo_1 (.clk_os(clk_os), .reset_os(reset_os),
		.i_valid(cap_valid), .i_pixel(line1_pixel), .o_line_pixel(line2_pixel));

	// one horizontal summer per window row
	box_row box_row_0 (.clk_os(clk_os), .reset_os(reset_os),
		.i_valid(cap_valid), .i_pixel(cap_pixel), .o_row_sum(row_sum_0));

	box_row box_row_1 (.clk_os(clk_os), .reset_os(reset_os),
		.i_valid(cap_valid), .i_pixel(line1_pixel), .o_row_sum(row_sum_1));

	box_row box_row_2 (.clk_os(clk_os), .reset_os(reset_os),
		.i_valid(cap_valid), .i_pixel(line2_pixel), .o_row_sum(row_sum_2));

	box_output u_output (.clk_os(clk_os), .reset_os(reset_os),
		.i_valid(cap_valid), .i_window_full(cap_full), .i_row_sums(row_sums),
		.o_sum_valid(o_sum_valid), .o_box_sum(o_box_sum), .o_window_full(o_window_full));

endmodule

`default_nettype wire

/* verification/box_filter_tb.sv */
`timescale 1ns/10ps
`default_nettype none

// directed testbench for the 3x3 box filter, with a raster frame model and an output monitor
module box_filter_tb
	import box_pkg::*;
();

	localparam int  CLK_PERIOD    = 8;
	localparam int  FRAME_H       = 6;  // test frames are six lines high
	localparam int  MAX_GAP       = 4;  // longest idle run between two strobes
	localparam int  TOTAL_STROBES = 7 * FRAME_H * FRAME_WIDTH + 25;
	localparam int  MARGIN_CYCLES = 400;  // reset, drains and the closing idle cycles
	localparam int  WATCHDOG_TIME = (TOTAL_STROBES * (MAX_GAP + 1) + MARGIN_CYCLES) * CLK_PERIOD;
	localparam int  FULL_PER_FRAME = (FRAME_H - 2) * (FRAME_WIDTH - 2);
	// driven on a falling edge, sampled half a period later, out two cycles after that,
	// and seen by the monitor on the falling edge that follows
	localparam time OUT_DELAY = time'(3 * CLK_PERIOD);

	logic                 clk_os = 1'b0;
	logic                 reset_os;
	logic                 i_pixel_valid;
	logic [PIXEL_W-1:0]   i_pixel;
	logic                 i_frame_start;
	logic                 o_sum_valid;
	logic [BOX_SUM_W-1:0] o_box_sum;
	logic                 o_window_full;

	logic [PIXEL_W-1:0]   stim_frame [FRAME_H][FRAME_WIDTH];   // pixels of the frame to send
	logic [PIXEL_W-1:0]   saved_frame [FRAME_H][FRAME_WIDTH];  // kept for the idle gap rerun
	logic [PIXEL_W-1:0]   ref_frame [FRAME_H][FRAME_WIDTH];    // model copy of the current frame
	logic [BOX_SUM_W-1:0] exp_sum [$];
	logic                 exp_full [$];
	time                  exp_time [$];
	int                   value_errors = 0;
	int                   strobe_errors = 0;
	int                   full_count = 0;  // full outputs seen since the last clear

	box_filter_top uut (.clk_os(clk_os), .reset_os(reset_os), .i_pixel_valid(i_pixel_valid),
		.i_pixel(i_pixel), .i_frame_start(i_frame_start), .o_sum_valid(o_sum_valid),
		.o_box_sum(o_box_sum), .o_window_full(o_window_full));

	always #(CLK_PERIOD / 2) clk_os = ~clk_os;

	task automatic check_sum(input string name, input logic [BOX_SUM_W-1:0] want,
		input logic [BOX_SUM_W-1:0] got);
		if (want !== got)
		begin
			$display("ERROR %s expected %h actual %h at %0t", name, want, got, $time);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic want, input logic got);
		if (want !== got)
		begin
			$display("ERROR %s expected %h actual %h at %0t", name, want, got, $time);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input int want, input int got);
		if (want != got)
		begin
			$display("ERROR %s expected %h actual %h", name, want, got);
			value_errors++;
		end
	endtask

	// 3x3 sum over the model frame, rows row-2..row and columns col-2..col
	function automatic int model_sum(input int row, input int col);
		int total;
		total = 0;
		for (int r = row - (WIN_SIZE - 1); r <= row; r++)
			for (int c = col - (WIN_SIZE - 1); c <= col; c++)
				total += int'(ref_frame[r][c]);
		return total;
	endfunction

	// one strobe, and the result the model expects for it
	task automatic send_pixel(input int row, input int col, input logic [PIXEL_W-1:0] pix);
		logic full;
		@(negedge clk_os);
		i_pixel_valid = 1'b1;
		i_pixel       = pix;
		i_frame_start = (row == 0 && col == 0);  // first pixel of every frame
		ref_frame[row][col] = pix;
		full = (row >= WIN_SIZE - 1) && (col >= WIN_SIZE - 1);
		exp_full.push_back(full);
		exp_sum.push_back(full ? BOX_SUM_W'(model_sum(row, col)) : '0);
		exp_time.push_back($time + OUT_DELAY);
	endtask

	task automatic idle_cycle();
		@(negedge clk_os);
		i_pixel_valid = 1'b0;
		i_frame_start = 1'b0;
	endtask

	task automatic random_frame();
		for (int r = 0; r < FRAME_H; r++)
			for (int c = 0; c < FRAME_WIDTH; c++)
				stim_frame[r][c] = PIXEL_W'($urandom_range(4095, 0));
	endtask

	// raster order, with a random idle run of 0 to max_gap cycles after each pixel
	task automatic send_frame(input int max_gap);
		int gap;
		for (int r = 0; r < FRAME_H; r++)
			for (int c = 0; c < FRAME_WIDTH; c++)
			begin
				send_pixel(r, c, stim_frame[r][c]);
				gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
				repeat (gap) idle_cycle();
			end
	endtask

	// waits until every queued result has come out, a few cycles at most
	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_sum.size() != 0 && cycles < 20)
		begin
			@(negedge clk_os);
			cycles++;
		end
		if (exp_sum.size() != 0)
		begin
			$display("%0d output strobes never arrived by %0t", exp_sum.size(), $time);
			strobe_errors++;
			exp_sum.delete();
			exp_full.delete();
			exp_time.delete();
		end
	endtask

	task automatic test_back_to_back();
		random_frame();
		saved_frame = stim_frame;
		send_frame(0);
		idle_cycle();
		wait_drain();
	endtask

	task automatic test_flag_pattern();
		random_frame();
		full_count = 0;
		send_frame(0);
		idle_cycle();
		wait_drain();
		check_count("full window count", FULL_PER_FRAME, full_count);
	endtask

	// same pixels as the first test, the delays count strobes so the sums match
	task automatic test_idle_gaps();
		stim_frame = saved_frame;
		send_frame(MAX_GAP);
		idle_cycle();
		wait_drain();
	endtask

	// second frame follows straight on, its first two lines must not count as full
	task automatic test_new_frame();
		full_count = 0;
		random_frame();
		send_frame(0);
		random_frame();
		send_frame(1);
		idle_cycle();
		wait_drain();
		check_count("full window count over two frames", 2 * FULL_PER_FRAME, full_count);
	endtask

	task automatic test_full_scale();
		for (int r = 0; r < FRAME_H; r++)
			for (int c = 0; c < FRAME_WIDTH; c++)
				stim_frame[r][c] = '1;
		send_frame(0);
		idle_cycle();
		wait_drain();
	endtask

	task automatic test_mid_frame_reset();
		random_frame();
		for (int i = 0; i < 25; i++)
			send_pixel(i / FRAME_WIDTH, i % FRAME_WIDTH,
				stim_frame[i / FRAME_WIDTH][i % FRAME_WIDTH]);
		@(negedge clk_os);
		i_pixel_valid = 1'b0;
		i_frame_start = 1'b0;
		reset_os      = 1'b1;  // pixels still in the pipeline are thrown away
		exp_sum.delete();
		exp_full.delete();
		exp_time.delete();
		repeat (3)
		begin
			@(negedge clk_os);
			check_flag("o_sum_valid", 1'b0, o_sum_valid);
			check_flag("o_window_full", 1'b0, o_window_full);
		end
		reset_os = 1'b0;
		random_frame();
		send_frame(0);
		idle_cycle();
		wait_drain();
	endtask

	// every output strobe is matched against the oldest pending result
	always @(negedge clk_os)
	begin
		logic [BOX_SUM_W-1:0] want_sum;
		logic                 want_full;
		time                  want_time;
		if (!reset_os && o_sum_valid)
		begin
			if (exp_sum.size() == 0)
			begin
				$display("output strobe at %0t with no pixel in flight", $time);
				strobe_errors++;
			end
			else
			begin
				want_sum  = exp_sum.pop_front();
				want_full = exp_full.pop_front();
				want_time = exp_time.pop_front();
				check_flag("o_window_full", want_full, o_window_full);
				if (want_full)
					check_sum("o_box_sum", want_sum, o_box_sum);  // only full windows carry a sum
				if ($time != want_time)
				begin
					$display("output strobe at %0t, expected it at %0t", $time, want_time);
					strobe_errors++;
				end
				if (o_window_full)
					full_count++;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_TIME);
		$display("watchdog ran out at %0t before the tests finished", $time);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h7c94_0c21));
		reset_os      = 1'b1;
		i_pixel_valid = 1'b0;
		i_pixel       = '0;
		i_frame_start = 1'b0;
		repeat (3) @(posedge clk_os);
		@(negedge clk_os);
		reset_os = 1'b0;
		test_back_to_back();
		test_flag_pattern();
		test_idle_gaps();
		test_new_frame();
		test_full_scale();
		test_mid_frame_reset();
		repeat (4) idle_cycle();  // room for a stray late strobe to show up
		$display("value errors: %0d, strobe errors: %0d", value_errors, strobe_errors);
		if (value_errors == 0 && strobe_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
source/box_pkg.sv
source/pixel_capture.sv
source/line_fifo.sv
source/box_row.sv
source/box_output.sv
source/box_filter_top.sv
verification/box_filter_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the box filter testbench with Verilator and runs it.
# The exit status is 0 only when the run prints the pass message.

cd "$(dirname "$0")" || exit 1

SIM_DIR=obj_dir
SIM_BIN=box_filter_sim

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module box_filter_tb \
	-Mdir "$SIM_DIR" -o "$SIM_BIN" \
	|| { echo "verilator build failed"; exit 1; }

# keep the simulation output on screen and search it for the pass line
SIM_OUT=$("./$SIM_DIR/$SIM_BIN") ; echo "$SIM_OUT"

echo "$SIM_OUT" | grep -qx "ALL CHECKS PASSED" \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }
